// ==== Makefile ====
# Verilator build for the vga subsystem testbench

LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module vga_tb -f sources.f

# pass only when the log holds the pass line
sim:
	verilator --binary --timing --assert --top-module vga_tb -f sources.f -o vga_sim
	./obj_dir/vga_sim +verilator+error+limit+1000 | tee $(LOG)
	grep -qx "PASS: all tests" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== design/pattern_gen.sv ====
//******************************
// raster pattern source
// covers the 640x480 visible area only
// credit based, no ready from the fifo
// mode and colour sampled at pixel (0,0)
//******************************
`timescale 1ns/100ps
`default_nettype none

module pattern_gen (
  input  logic                 rst,
  input  logic                 clk,
  input  pixel_pkg::pat_mode_t mode,
  input  pixel_pkg::rgb_t      solid,
  input  logic                 credit_ret,
  output logic                 pix_valid,
  output pixel_pkg::rgb_t      pix
);
  import vga_timing_pkg::*;
  import pixel_pkg::*;

  credit_t   credits;
  col_t      x;
  row_t      y;
  pat_mode_t mode_q;
  rgb_t      solid_q;
  logic      at_origin;
  logic      last_x;
  logic      last_y;
  pat_mode_t mode_cur;
  rgb_t      solid_cur;

  // colour rule for one pixel
  function automatic rgb_t pat_color(pat_mode_t m, rgb_t s, col_t cx, row_t cy);
    logic [2:0] bar;
    rgb_t       c;
    bar = 3'(cx / col_t'(BAR_WIDTH));
    c   = '0;
    case (m)
      PAT_SOLID: c = s;
      PAT_BARS: begin
        c.red   = {4{bar[2]}};
        c.green = {4{bar[1]}};
        c.blue  = {4{bar[0]}};
      end
      // white where the square bits differ
      PAT_CHECKER: c = (cx[CHECKER_BIT] != cy[CHECKER_BIT]) ? '1 : '0;
      default: c = '0;
    endcase
    return c;
  endfunction

  assign at_origin = (x == '0) && (y == '0);
  assign last_x    = (x == col_t'(PXL_VISIBLE - 1));
  assign last_y    = (y == row_t'(LINE_VISIBLE - 1));

  // live settings on the first pixel of a frame, latched ones after
  assign mode_cur  = at_origin ? mode : mode_q;
  assign solid_cur = at_origin ? solid : solid_q;

  // send whenever a fifo slot is known free
  assign pix_valid = (credits != '0);
  assign pix       = pat_color(mode_cur, solid_cur, x, y);

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      credits <= credit_t'(FIFO_DEPTH);
      x       <= '0;
      y       <= '0;
      mode_q  <= PAT_SOLID;
      solid_q <= '0;
    end else begin
      credits <= credits - credit_t'(pix_valid) + credit_t'(credit_ret);
      if (pix_valid) begin
        if (at_origin) begin
          mode_q  <= mode;
          solid_q <= solid;
        end
        // raster order over the visible area
        x <= last_x ? '0 : x + col_t'(1);
        if (last_x) begin
          y <= last_y ? '0 : y + row_t'(1);
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/pixel_fifo.sv ====
//******************************
// pixel fifo, FIFO_DEPTH entries
// no overflow check, the credits prevent it
// pop on empty is ignored
// one credit back the clock after each pop
//******************************
`timescale 1ns/100ps
`default_nettype none

module pixel_fifo (
  input  logic            rst,
  input  logic            clk,
  input  logic            pix_valid,
  input  pixel_pkg::rgb_t pix,
  input  logic            pop,
  output pixel_pkg::rgb_t head,
  output logic            empty,
  output logic            credit_ret
);
  import pixel_pkg::*;

  rgb_t                          mem [FIFO_DEPTH];
  logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
  logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
  credit_t                       count;
  logic                          do_pop;

  assign empty  = (count == '0);
  assign head   = mem[rd_ptr];
  assign do_pop = pop && !empty;

  // storage
  always_ff @(posedge rst) begin
    if (pix_valid) begin
      mem[wr_ptr] <= pix;
    end
  end

  // pointers wrap on their own width
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      credit_ret <= 1'b0;
    end else begin
      if (pix_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count      <= count + credit_t'(pix_valid) - credit_t'(do_pop);
      // slot freed, hand the credit back
      credit_ret <= do_pop;
    end
  end

endmodule

`default_nettype wire

// ==== design/pixel_pkg.sv ====
//******************************
// pixel colour and pattern types
// 12 bit colour, 4 bits per channel
// fifo depth must stay a power of two
// register map is 2 bit address, 16 bit data
//******************************
`default_nettype none

package pixel_pkg;

  typedef logic [3:0] chan_t;

  // red in the top nibble, blue in the bottom one
  typedef struct packed {
    chan_t red;
    chan_t green;
    chan_t blue;
  } rgb_t;

  typedef enum logic [1:0] {
    PAT_SOLID   = 2'd0,
    PAT_BARS    = 2'd1,
    PAT_CHECKER = 2'd2
  } pat_mode_t;

  // colour bar width in columns, eight bars over the line
  localparam int BAR_WIDTH = 80;
  // column and row bit that flips the checker square
  localparam int CHECKER_BIT = 5;

  // pixel fifo entries, also the starting credit count
  localparam int FIFO_DEPTH = 8;
  // holds 0 to FIFO_DEPTH
  typedef logic [3:0] credit_t;

  typedef logic [1:0]  cfg_addr_t;
  typedef logic [15:0] cfg_data_t;

  // register addresses
  localparam cfg_addr_t ADDR_MODE   = 2'd0;
  localparam cfg_addr_t ADDR_COLOR  = 2'd1;
  localparam cfg_addr_t ADDR_STATUS = 2'd2;

endpackage

`default_nettype wire

// ==== design/vga_cfg_regs.sv ====
//******************************
// pattern config and status regs
// write strobe, read is combinational on cfg_addr
// status bit 0 is sticky underflow, write 1 clears
// illegal mode codes are dropped
//******************************
`timescale 1ns/100ps
`default_nettype none

module vga_cfg_regs (
  input  logic                 rst,
  input  logic                 clk,
  input  logic                 cfg_wr,
  input  pixel_pkg::cfg_addr_t cfg_addr,
  input  pixel_pkg::cfg_data_t cfg_wdata,
  input  logic                 underflow,
  output pixel_pkg::cfg_data_t cfg_rdata,
  output pixel_pkg::pat_mode_t mode,
  output pixel_pkg::rgb_t      solid
);
  import pixel_pkg::*;

  logic uflow_sticky;

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      mode         <= PAT_SOLID;
      solid        <= '0;
      uflow_sticky <= 1'b0;
    end else begin
      if (cfg_wr && cfg_addr == ADDR_MODE) begin
        // keep the old mode on the unused code
        case (pat_mode_t'(cfg_wdata[1:0]))
          PAT_SOLID, PAT_BARS, PAT_CHECKER: mode <= pat_mode_t'(cfg_wdata[1:0]);
          default: ;
        endcase
      end
      if (cfg_wr && cfg_addr == ADDR_COLOR) begin
        solid <= rgb_t'(cfg_wdata[11:0]);
      end
      // a new underflow wins over a clear in the same clock
      if (underflow) begin
        uflow_sticky <= 1'b1;
      end else if (cfg_wr && cfg_addr == ADDR_STATUS && cfg_wdata[0]) begin
        uflow_sticky <= 1'b0;
      end
    end
  end

  // read mux, zero for unmapped addresses
  always_comb begin
    case (cfg_addr)
      ADDR_MODE:   cfg_rdata = {14'd0, mode};
      ADDR_COLOR:  cfg_rdata = {4'd0, solid};
      ADDR_STATUS: cfg_rdata = {15'd0, uflow_sticky};
      default:     cfg_rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== design/vga_scanout.sv ====
//******************************
// scanout and output register
// one pop per visible pixel tick
// black outside visible, black on underflow
// every output one clock behind vga_sync
//******************************
`timescale 1ns/100ps
`default_nettype none

module vga_scanout (
  input  logic                  rst,
  input  logic                  clk,
  input  vga_timing_pkg::sync_t sync,
  input  pixel_pkg::rgb_t       head,
  input  logic                  empty,
  output logic                  pop,
  output logic                  underflow,
  output logic                  hsync,
  output logic                  vsync,
  output logic                  visible,
  output logic                  pxl_tick,
  output vga_timing_pkg::col_t  col,
  output vga_timing_pkg::row_t  row,
  output pixel_pkg::rgb_t       rgb
);
  import vga_timing_pkg::*;
  import pixel_pkg::*;

  // take the head on a visible tick
  assign pop = sync.pxl_tick && sync.visible && !empty;

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      pxl_tick  <= 1'b0;
      visible   <= 1'b0;
      hsync     <= ~SYNC_ACT;
      vsync     <= ~SYNC_ACT;
      col       <= '0;
      row       <= '0;
      rgb       <= '0;
      underflow <= 1'b0;
    end else begin
      pxl_tick  <= sync.pxl_tick;
      visible   <= sync.visible;
      hsync     <= sync.hsync;
      vsync     <= sync.vsync;
      col       <= sync.col;
      row       <= sync.row;
      // fifo ran dry on a visible pixel
      underflow <= sync.pxl_tick && sync.visible && empty;
      // blank follows visible clock for clock, so colour drops with it
      if (!sync.visible) begin
        rgb <= '0;
      end else if (sync.pxl_tick) begin
        rgb <= empty ? '0 : head;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/vga_sync.sv ====
//******************************
// vga timing generator, 640x480
// rst is the clock, clk the async active high reset
// pixel tick once every four clocks
// all outputs registered from the counters
//******************************
`timescale 1ns/100ps
`default_nettype none

module vga_sync (
  input  logic                  rst,
  input  logic                  clk,
  output vga_timing_pkg::sync_t sync
);
  import vga_timing_pkg::*;

  logic [1:0] cnt_clk;
  col_t       cnt_pxl;
  row_t       cnt_line;

  logic       tick_nxt;
  logic       end_pxl;
  logic       end_line;
  logic       new_line;

  logic       vis_pxl;
  logic       vis_line;
  logic       hsync_nxt;
  logic       vsync_nxt;

  // clock divider, last count of each pixel period
  assign tick_nxt = (cnt_clk == 2'(CLKS_PER_PXL - 1));

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      cnt_clk <= '0;
    end else if (tick_nxt) begin
      cnt_clk <= '0;
    end else begin
      cnt_clk <= cnt_clk + 2'd1;
    end
  end

  // counters step on the registered tick
  assign end_pxl  = (cnt_pxl == col_t'(PXL_TOTAL - 1));
  assign end_line = (cnt_line == row_t'(LINE_TOTAL - 1));
  assign new_line = end_pxl && sync.pxl_tick;

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      cnt_pxl <= '0;
    end else if (sync.pxl_tick) begin
      cnt_pxl <= end_pxl ? '0 : cnt_pxl + col_t'(1);
    end
  end

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      cnt_line <= '0;
    end else if (new_line) begin
      cnt_line <= end_line ? '0 : cnt_line + row_t'(1);
    end
  end

  // horizontal decode
  assign vis_pxl   = (cnt_pxl < col_t'(PXL_VISIBLE));
  assign hsync_nxt = (cnt_pxl >= col_t'(PXL_2_FPORCH) && cnt_pxl < col_t'(PXL_2_SYNCH)) ?
                     SYNC_ACT : ~SYNC_ACT;

  // vertical decode
  assign vis_line  = (cnt_line < row_t'(LINE_VISIBLE));
  assign vsync_nxt = (cnt_line >= row_t'(LINE_2_FPORCH) && cnt_line < row_t'(LINE_2_SYNCH)) ?
                     SYNC_ACT : ~SYNC_ACT;

  // output stage, one clock after the counters
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      sync <= '{pxl_tick: 1'b0, visible: 1'b0, hsync: ~SYNC_ACT, vsync: ~SYNC_ACT,
                col: '0, row: '0};
    end else begin
      sync.pxl_tick <= tick_nxt;
      sync.visible  <= vis_pxl && vis_line;
      sync.hsync    <= hsync_nxt;
      sync.vsync    <= vsync_nxt;
      sync.col      <= cnt_pxl;
      sync.row      <= cnt_line;
    end
  end

endmodule

`default_nettype wire

// ==== design/vga_timing_pkg.sv ====
//******************************
// 640x480 vga timing constants
// counts are zero based and totals are exclusive ends
// four system clocks per pixel, no other modes
// sync pulses are active low
//******************************
`default_nettype none

package vga_timing_pkg;

  // horizontal counts in pixels
  localparam int PXL_VISIBLE  = 640;
  localparam int PXL_2_FPORCH = 656;
  localparam int PXL_2_SYNCH  = 752;
  localparam int PXL_TOTAL    = 800;

  // vertical counts in lines
  localparam int LINE_VISIBLE  = 480;
  localparam int LINE_2_FPORCH = 489;
  localparam int LINE_2_SYNCH  = 491;
  localparam int LINE_TOTAL    = 520;

  // system clocks per pixel
  localparam int CLKS_PER_PXL = 4;

  // active level of hsync and vsync
  localparam logic SYNC_ACT = 1'b0;

  typedef logic [9:0] col_t;
  typedef logic [9:0] row_t;

  // timing bundle from the sync generator, 24 bits
  typedef struct packed {
    logic pxl_tick;
    logic visible;
    logic hsync;
    logic vsync;
    col_t col;
    row_t row;
  } sync_t;

endpackage

`default_nettype wire

// ==== design/vga_top.sv ====
//******************************
// vga subsystem top
// rst is the clock, clk the async active high reset
// outputs two clocks after the timing counters
//******************************
`timescale 1ns/100ps
`default_nettype none

module vga_top (
  input  logic                 rst,
  input  logic                 clk,
  input  logic                 cfg_wr,
  input  pixel_pkg::cfg_addr_t cfg_addr,
  input  pixel_pkg::cfg_data_t cfg_wdata,
  output pixel_pkg::cfg_data_t cfg_rdata,
  output logic                 hsync,
  output logic                 vsync,
  output logic                 visible,
  output logic                 pxl_tick,
  output vga_timing_pkg::col_t col,
  output vga_timing_pkg::row_t row,
  output pixel_pkg::rgb_t      rgb
);
  import vga_timing_pkg::*;
  import pixel_pkg::*;

  sync_t     sync_bus;
  pat_mode_t mode;
  rgb_t      solid;
  logic      pix_valid;
  rgb_t      pix;
  logic      credit_ret;
  rgb_t      head;
  logic      empty;
  logic      pop;
  logic      underflow;

  vga_sync u_sync (
    .rst  (rst),
    .clk  (clk),
    .sync (sync_bus)
  );

  vga_cfg_regs u_regs (
    .rst       (rst),
    .clk       (clk),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .underflow (underflow),
    .cfg_rdata (cfg_rdata),
    .mode      (mode),
    .solid     (solid)
  );

  pattern_gen u_pat (
    .rst        (rst),
    .clk        (clk),
    .mode       (mode),
    .solid      (solid),
    .credit_ret (credit_ret),
    .pix_valid  (pix_valid),
    .pix        (pix)
  );

  pixel_fifo u_fifo (
    .rst        (rst),
    .clk        (clk),
    .pix_valid  (pix_valid),
    .pix        (pix),
    .pop        (pop),
    .head       (head),
    .empty      (empty),
    .credit_ret (credit_ret)
  );

  vga_scanout u_scan (
    .rst       (rst),
    .clk       (clk),
    .sync      (sync_bus),
    .head      (head),
    .empty     (empty),
    .pop       (pop),
    .underflow (underflow),
    .hsync     (hsync),
    .vsync     (vsync),
    .visible   (visible),
    .pxl_tick  (pxl_tick),
    .col       (col),
    .row       (row),
    .rgb       (rgb)
  );

endmodule

`default_nettype wire

// ==== dv/vga_chk.sv ====
//******************************
// vga output assertions, bound to vga_top
// checks run from the first pixel tick on
// fail_cnt is read by the testbench
//******************************
`timescale 1ns/100ps
`default_nettype none

module vga_chk (
  input logic                 rst,
  input logic                 clk,
  input logic                 hsync,
  input logic                 vsync,
  input logic                 visible,
  input logic                 pxl_tick,
  input vga_timing_pkg::col_t col,
  input vga_timing_pkg::row_t row,
  input pixel_pkg::rgb_t      rgb,
  input logic                 underflow
);
  import vga_timing_pkg::*;
  import pixel_pkg::*;

  int   fail_cnt = 0;
  logic seen_tick;

  // next column on the following tick
  function automatic col_t col_after(col_t c);
    return (c == col_t'(PXL_TOTAL - 1)) ? '0 : c + col_t'(1);
  endfunction

  // line steps only when the column wraps
  function automatic row_t row_after(row_t r, col_t c);
    if (c != col_t'(PXL_TOTAL - 1)) begin
      return r;
    end
    return (r == row_t'(LINE_TOTAL - 1)) ? '0 : r + row_t'(1);
  endfunction

  // past values only count once the first tick is out
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      seen_tick <= 1'b0;
    end else if (pxl_tick) begin
      seen_tick <= 1'b1;
    end
  end

  // hsync pulse over columns 656 to 751
  a_hsync: assert property (@(posedge rst) disable iff (clk)
    pxl_tick |-> ((hsync == SYNC_ACT) ==
                  (col >= col_t'(PXL_2_FPORCH) && col <= col_t'(PXL_2_SYNCH - 1))))
    else begin fail_cnt++; $error("hsync wrong at col %0d", col); end

  // vsync pulse over lines 489 and 490
  a_vsync: assert property (@(posedge rst) disable iff (clk)
    pxl_tick |-> ((vsync == SYNC_ACT) ==
                  (row >= row_t'(LINE_2_FPORCH) && row <= row_t'(LINE_2_SYNCH - 1))))
    else begin fail_cnt++; $error("vsync wrong at row %0d", row); end

  a_visible: assert property (@(posedge rst) disable iff (clk)
    pxl_tick |-> (visible == (col < col_t'(PXL_VISIBLE) && row < row_t'(LINE_VISIBLE))))
    else begin fail_cnt++; $error("visible wrong at col %0d row %0d", col, row); end

  // tick high once in four clocks, low for the three between
  a_tick_rate: assert property (@(posedge rst) disable iff (clk)
    seen_tick |-> (pxl_tick == ($past(pxl_tick, 4) && !$past(pxl_tick, 1) &&
                                !$past(pxl_tick, 2) && !$past(pxl_tick, 3))))
    else begin fail_cnt++; $error("pixel tick out of step"); end

  a_col_step: assert property (@(posedge rst) disable iff (clk)
    (pxl_tick && seen_tick) |-> (col == col_after($past(col, 4))))
    else begin fail_cnt++; $error("column did not step, now %0d", col); end

  a_row_step: assert property (@(posedge rst) disable iff (clk)
    (pxl_tick && seen_tick) |-> (row == row_after($past(row, 4), $past(col, 4))))
    else begin fail_cnt++; $error("line did not step, now %0d", row); end

  // blanking
  a_blank: assert property (@(posedge rst) disable iff (clk)
    !visible |-> (rgb == '0))
    else begin fail_cnt++; $error("colour %h outside visible area", rgb); end

  // fifo must never run dry
  a_no_underflow: assert property (@(posedge rst) disable iff (clk)
    !underflow)
    else begin fail_cnt++; $error("pixel fifo underflow"); end

endmodule

bind vga_top vga_chk u_chk (
  .rst       (rst),
  .clk       (clk),
  .hsync     (hsync),
  .vsync     (vsync),
  .visible   (visible),
  .pxl_tick  (pxl_tick),
  .col       (col),
  .row       (row),
  .rgb       (rgb),
  .underflow (underflow)
);

`default_nettype wire

// ==== dv/vga_tb.sv ====
//******************************
// vga subsystem testbench
// rst is the clock, clk the reset
// frame checks need a fifo that never underflows
// about four frames of sim time
//******************************
`timescale 1ns/100ps
`default_nettype none

module vga_tb;
  import vga_timing_pkg::*;
  import pixel_pkg::*;

  localparam int HALF_PERIOD = 4;
  localparam int FRAME_CLKS  = PXL_TOTAL * LINE_TOTAL * CLKS_PER_PXL;
  // one partial frame, three checked ones, then slack
  localparam int RUN_CLKS    = 4 * FRAME_CLKS + 2000;
  // next mode is written on this line
  localparam int WRITE_ROW   = 240;

  logic      rst;
  logic      clk;
  logic      cfg_wr;
  cfg_addr_t cfg_addr;
  cfg_data_t cfg_wdata;
  cfg_data_t cfg_rdata;
  logic      hsync;
  logic      vsync;
  logic      visible;
  logic      pxl_tick;
  col_t      col;
  row_t      row;
  rgb_t      rgb;

  int tests_run;
  int tests_failed;
  int errors;
  int errs;

  vga_top UUT (
    .rst       (rst),
    .clk       (clk),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .hsync     (hsync),
    .vsync     (vsync),
    .visible   (visible),
    .pxl_tick  (pxl_tick),
    .col       (col),
    .row       (row),
    .rgb       (rgb)
  );

  always #(HALF_PERIOD) rst = ~rst;

  // expected colour at one visible pixel
  function automatic rgb_t expect_pixel(pat_mode_t m, rgb_t s, col_t c, row_t r);
    rgb_t e;
    int   bar;
    int   sq;
    e   = '0;
    bar = int'(c) / BAR_WIDTH;
    sq  = ((int'(c) >> CHECKER_BIT) ^ (int'(r) >> CHECKER_BIT)) & 1;
    if (m == PAT_SOLID) begin
      e = s;
    end else if (m == PAT_BARS) begin
      e.red   = ((bar & 4) != 0) ? 4'hf : 4'h0;
      e.green = ((bar & 2) != 0) ? 4'hf : 4'h0;
      e.blue  = ((bar & 1) != 0) ? 4'hf : 4'h0;
    end else if (m == PAT_CHECKER && sq != 0) begin
      e = '{red: 4'hf, green: 4'hf, blue: 4'hf};
    end
    return e;
  endfunction

  // called on a falling edge, returns one edge later
  task automatic reg_write(input cfg_addr_t addr, input cfg_data_t data);
    cfg_wr    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(negedge rst);
    cfg_wr    = 1'b0;
  endtask

  task automatic reg_expect(input string name, input cfg_addr_t addr,
                            input cfg_data_t exp, inout int n);
    cfg_addr = addr;
    @(negedge rst);
    assert (cfg_rdata == exp) else begin
      $display("mismatch %s addr %0d: expected %h, actual %h", name, addr, exp, cfg_rdata);
      n++;
    end
  endtask

  // one line per test, assertion failures from vga_chk included
  task automatic end_test(input string name, input int n, input int chk_base);
    int chk_errs;
    chk_errs = UUT.u_chk.fail_cnt - chk_base;
    tests_run++;
    errors += n + chk_errs;
    if (n + chk_errs == 0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors, %0d assertion failures", name, n, chk_errs);
    end
  endtask

  task automatic wait_frame_start();
    @(negedge rst);
    while (!(pxl_tick && col == '0 && row == '0)) begin
      @(negedge rst);
    end
  endtask

  // checks a whole frame, optionally writing the next mode mid frame
  task automatic check_frame(input string name, input pat_mode_t m, input rgb_t s,
                             input logic write_next, input pat_mode_t next_mode);
    int   n;
    int   pixels;
    int   chk_base;
    logic done;
    rgb_t exp;
    n        = 0;
    pixels   = 0;
    done     = 1'b0;
    chk_base = UUT.u_chk.fail_cnt;
    wait_frame_start();
    while (!done) begin
      if (pxl_tick && visible) begin
        exp = expect_pixel(m, s, col, row);
        pixels++;
        assert (rgb == exp) else begin
          $display("mismatch %s col %0d row %0d: expected %h, actual %h",
                   name, col, row, exp, rgb);
          n++;
        end
      end
      if (write_next && pxl_tick && col == '0 && row == row_t'(WRITE_ROW)) begin
        reg_write(ADDR_MODE, cfg_data_t'(next_mode));
      end
      if (pxl_tick && col == col_t'(PXL_VISIBLE - 1) && row == row_t'(LINE_VISIBLE - 1)) begin
        done = 1'b1;
      end else begin
        @(negedge rst);
      end
    end
    assert (pixels == PXL_VISIBLE * LINE_VISIBLE) else begin
      $display("frame %s covered %0d visible pixels instead of %0d", name, pixels,
               PXL_VISIBLE * LINE_VISIBLE);
      n++;
    end
    end_test(name, n, chk_base);
  endtask

  initial begin
    int chk_base;
    rst          = 1'b0;
    clk          = 1'b1;
    cfg_wr       = 1'b0;
    cfg_addr     = '0;
    cfg_wdata    = '0;
    tests_run    = 0;
    tests_failed = 0;
    errors       = 0;
    repeat (5) @(negedge rst);
    clk = 1'b0;
    @(negedge rst);

    // register write and read-back, ends on solid
    errs     = 0;
    chk_base = 0;
    reg_write(ADDR_COLOR, 16'h0a5c);
    reg_expect("regs", ADDR_COLOR, 16'h0a5c, errs);
    reg_write(ADDR_MODE, cfg_data_t'(PAT_CHECKER));
    reg_expect("regs", ADDR_MODE, cfg_data_t'(PAT_CHECKER), errs);
    reg_write(ADDR_MODE, cfg_data_t'(PAT_BARS));
    reg_expect("regs", ADDR_MODE, cfg_data_t'(PAT_BARS), errs);
    reg_write(ADDR_MODE, cfg_data_t'(PAT_SOLID));
    reg_expect("regs", ADDR_MODE, cfg_data_t'(PAT_SOLID), errs);
    // unmapped address reads zero
    reg_expect("regs", 2'd3, 16'h0000, errs);
    end_test("regs", errs, chk_base);

    // each frame carries the mode written in the one before
    check_frame("frame_solid", PAT_SOLID, rgb_t'(12'ha5c), 1'b1, PAT_BARS);
    check_frame("frame_bars", PAT_BARS, rgb_t'(12'ha5c), 1'b1, PAT_CHECKER);
    check_frame("frame_checker", PAT_CHECKER, rgb_t'(12'ha5c), 1'b0, PAT_CHECKER);

    // sticky underflow never set, clear keeps it zero
    errs     = 0;
    chk_base = UUT.u_chk.fail_cnt;
    reg_expect("status", ADDR_STATUS, 16'h0000, errs);
    reg_write(ADDR_STATUS, 16'h0001);
    reg_expect("status", ADDR_STATUS, 16'h0000, errs);
    end_test("status", errs, chk_base);

    $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (tests_failed == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(2 * HALF_PERIOD * RUN_CLKS);
    $display("timeout: tests did not finish within %0d clocks", RUN_CLKS);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
design/vga_timing_pkg.sv
design/pixel_pkg.sv
design/vga_sync.sv
design/vga_cfg_regs.sv
design/pattern_gen.sv
design/pixel_fifo.sv
design/vga_scanout.sv
design/vga_top.sv
dv/vga_chk.sv
dv/vga_tb.sv
